// ==== verilog/dp_pkg.sv ====
package dp_pkg;

    localparam int LANE_W     = 32;
    localparam int NUM_LANES  = 4;
    localparam int PHIT_W     = LANE_W * NUM_LANES;
    localparam int KEEP_W     = PHIT_W / 8;
    localparam int LANE_KEEP  = LANE_W / 8;               // tkeep bits per lane
    localparam int NUM_COL    = 2;
    localparam int FIFO_DEPTH = 16;
    localparam int FREE_W     = $clog2(FIFO_DEPTH + 1);   // free-slot counter width

    typedef logic [LANE_W-1:0]    lane_t;
    typedef logic [PHIT_W-1:0]    phit_t;
    typedef logic [KEEP_W-1:0]    keep_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    typedef enum logic [1:0] {
        OP_PASS,
        OP_ADD,
        OP_MUL,
        OP_MAC
    } col_op_e;

    typedef enum logic {
        STEADY_OFF,
        STEADY_ON
    } steady_e;

    // external stream beat, valid and ready travel separately
    typedef struct packed {
        phit_t data;
        keep_t keep;
        logic  last;
    } axis_beat_t;

    // beat inside the column chain
    typedef struct packed {
        phit_t      data;
        lane_mask_t lane_valid;
        logic       last;
    } lane_beat_t;

    typedef struct packed {
        col_op_e op;
        lane_t   operand;
    } col_cfg_t;

endpackage

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_push,
    input  logic [WIDTH-1:0]           i_din,
    input  logic                       i_pop,
    output logic [WIDTH-1:0]           o_dout,
    output logic                       o_empty,
    output logic                       o_full,
    output logic [$clog2(DEPTH+1)-1:0] o_free
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = i_push && !o_full;   // push on full is dropped
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    assign o_dout  = mem[rd_ptr];       // first word fall through
    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_free  = CNT_W'(DEPTH) - count;

endmodule

// ==== verilog/steady_ctrl.sv ====
`timescale 1ns/1ps

module steady_ctrl import dp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_done_loader,
    input  logic       i_ap_done,
    // external side
    input  axis_beat_t i_ext_beat,
    input  logic       i_ext_valid,
    input  logic       i_ext_out_ready,
    output logic       o_ext_in_ready,
    output axis_beat_t o_ext_beat,
    output logic       o_ext_out_valid,
    // internal side
    input  logic       i_int_in_ready,
    input  axis_beat_t i_int_beat,
    input  logic       i_int_out_valid,
    output logic       o_int_in_valid,
    output logic       o_int_out_ready,
    output logic       o_done_steady
);
    steady_e state;
    steady_e state_next;
    logic    steady;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= STEADY_OFF;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            STEADY_OFF: state_next = i_done_loader ? STEADY_ON : STEADY_OFF;
            STEADY_ON:  state_next = i_ap_done ? STEADY_OFF : STEADY_ON;
            default:    state_next = STEADY_OFF;
        endcase
    end

    assign steady        = (state == STEADY_ON);
    assign o_done_steady = steady;

    // off: straight through, internal path sees nothing
    always_comb begin
        if (steady) begin
            o_ext_beat      = i_int_beat;
            o_ext_out_valid = i_int_out_valid;
            o_ext_in_ready  = i_int_in_ready;
        end else begin
            o_ext_beat      = i_ext_beat;
            o_ext_out_valid = i_ext_valid;
            o_ext_in_ready  = i_ext_out_ready;
        end
    end

    assign o_int_in_valid  = i_ext_valid && steady;
    assign o_int_out_ready = i_ext_out_ready && steady;

endmodule

// ==== verilog/stream_in_stage.sv ====
`timescale 1ns/1ps

module stream_in_stage import dp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  axis_beat_t i_beat,
    input  logic       i_valid,
    output logic       o_ready,
    input  logic       i_room,      // output stage can absorb the chain
    output lane_beat_t o_lane_beat,
    output logic       o_issue
);
    lane_beat_t push_beat;
    logic       fifo_empty;
    logic       fifo_full;
    logic       push;

    // a lane counts only when its whole word is kept
    always_comb begin
        push_beat.data = i_beat.data;
        push_beat.last = i_beat.last;
        for (int l = 0; l < NUM_LANES; l++) begin
            push_beat.lane_valid[l] = &i_beat.keep[l*LANE_KEEP +: LANE_KEEP];
        end
    end

    assign o_ready = !fifo_full;
    assign push    = i_valid && o_ready;

    // one beat per cycle into column 0
    assign o_issue = !fifo_empty && i_room;

    sync_fifo #(
        .WIDTH ($bits(lane_beat_t)),
        .DEPTH (FIFO_DEPTH)
    ) u_lane_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_push  (push),
        .i_din   (push_beat),
        .i_pop   (o_issue),
        .o_dout  (o_lane_beat),
        .o_empty (fifo_empty),
        .o_full  (fifo_full),
        .o_free  ()
    );

endmodule

// ==== verilog/column_pe.sv ====
`timescale 1ns/1ps

module column_pe import dp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  lane_beat_t i_beat,
    input  logic       i_issue,
    input  col_cfg_t   i_cfg,
    output lane_beat_t o_beat,
    output logic       o_issue
);
    lane_t      elem [NUM_LANES];
    lane_t      acc [NUM_LANES];
    lane_t      acc_next [NUM_LANES];
    lane_beat_t res;

    always_comb begin
        res = i_beat;               // invalid lanes pass untouched
        for (int l = 0; l < NUM_LANES; l++) begin
            elem[l]     = i_beat.data[l*LANE_W +: LANE_W];
            acc_next[l] = acc[l] + lane_t'(i_cfg.operand * elem[l]);
            if (i_beat.lane_valid[l]) begin
                case (i_cfg.op)
                    OP_ADD:  res.data[l*LANE_W +: LANE_W] = elem[l] + i_cfg.operand;
                    OP_MUL:  res.data[l*LANE_W +: LANE_W] = lane_t'(elem[l] * i_cfg.operand);
                    OP_MAC:  res.data[l*LANE_W +: LANE_W] = acc_next[l];
                    default: res.data[l*LANE_W +: LANE_W] = elem[l];
                endcase
            end
        end
    end

    // per-lane sums, restart after each frame
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                acc[l] <= '0;
            end
        end else if (i_issue) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (i_beat.last) begin
                    acc[l] <= '0;
                end else if (i_beat.lane_valid[l] && (i_cfg.op == OP_MAC)) begin
                    acc[l] <= acc_next[l];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_issue <= 1'b0;
        end else begin
            o_issue <= i_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (i_issue) begin
            o_beat <= res;
        end
    end

endmodule

// ==== verilog/stream_out_stage.sv ====
`timescale 1ns/1ps

module stream_out_stage import dp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  lane_beat_t i_lane_beat,
    input  logic       i_issue,
    input  logic       i_ready,
    output axis_beat_t o_beat,
    output logic       o_valid,
    output logic       o_room,
    output logic       o_frame_done
);
    lane_beat_t        head;
    logic              fifo_empty;
    logic [FREE_W-1:0] free;
    logic              pop;

    sync_fifo #(
        .WIDTH ($bits(lane_beat_t)),
        .DEPTH (FIFO_DEPTH)
    ) u_out_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_push  (i_issue),
        .i_din   (i_lane_beat),
        .i_pop   (pop),
        .o_dout  (head),
        .o_empty (fifo_empty),
        .o_full  (),
        .o_free  (free)
    );

    assign o_valid = !fifo_empty;
    assign pop     = o_valid && i_ready;

    // tkeep back from the lane mask
    always_comb begin
        o_beat.data = head.data;
        o_beat.last = head.last;
        for (int l = 0; l < NUM_LANES; l++) begin
            o_beat.keep[l*LANE_KEEP +: LANE_KEEP] = {LANE_KEEP{head.lane_valid[l]}};
        end
    end

    // room for every beat already in the chain plus the one issued now
    assign o_room = (free > FREE_W'(NUM_COL + 1));

    assign o_frame_done = pop && head.last;

endmodule

// ==== verilog/data_path.sv ====
`timescale 1ns/1ps

module data_path import dp_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  axis_beat_t                i_in_beat,
    input  logic                      i_in_valid,
    output logic                      o_in_ready,
    output axis_beat_t                o_out_beat,
    output logic                      o_out_valid,
    input  logic                      i_out_ready,
    input  logic                      i_done_loader,
    input  col_cfg_t [NUM_COL-1:0]    i_col_cfg,    // static while steady
    output logic                      o_done_steady,
    output logic                      o_ap_done
);
    logic       int_in_valid;
    logic       int_in_ready;
    logic       int_out_valid;
    logic       int_out_ready;
    axis_beat_t int_out_beat;
    logic       room;
    logic       frame_done;

    lane_beat_t         col_beat [NUM_COL+1];  // entry 0 is the input stage head
    logic [NUM_COL:0]   col_issue;

    steady_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .i_done_loader   (i_done_loader),
        .i_ap_done       (frame_done),
        .i_ext_beat      (i_in_beat),
        .i_ext_valid     (i_in_valid),
        .i_ext_out_ready (i_out_ready),
        .o_ext_in_ready  (o_in_ready),
        .o_ext_beat      (o_out_beat),
        .o_ext_out_valid (o_out_valid),
        .i_int_in_ready  (int_in_ready),
        .i_int_beat      (int_out_beat),
        .i_int_out_valid (int_out_valid),
        .o_int_in_valid  (int_in_valid),
        .o_int_out_ready (int_out_ready),
        .o_done_steady   (o_done_steady)
    );

    stream_in_stage u_in (
        .clk         (clk),
        .rst         (rst),
        .i_beat      (i_in_beat),
        .i_valid     (int_in_valid),
        .o_ready     (int_in_ready),
        .i_room      (room),
        .o_lane_beat (col_beat[0]),
        .o_issue     (col_issue[0])
    );

    for (genvar c = 0; c < NUM_COL; c++) begin : g_col
        column_pe u_pe (
            .clk     (clk),
            .rst     (rst),
            .i_beat  (col_beat[c]),
            .i_issue (col_issue[c]),
            .i_cfg   (i_col_cfg[c]),
            .o_beat  (col_beat[c+1]),
            .o_issue (col_issue[c+1])
        );
    end

    stream_out_stage u_out (
        .clk          (clk),
        .rst          (rst),
        .i_lane_beat  (col_beat[NUM_COL]),
        .i_issue      (col_issue[NUM_COL]),
        .i_ready      (int_out_ready),
        .o_beat       (int_out_beat),
        .o_valid      (int_out_valid),
        .o_room       (room),
        .o_frame_done (frame_done)
    );

    assign o_ap_done = frame_done;

endmodule

// ==== testbench/tb_data_path.sv ====
`timescale 1ns/1ps

module tb_data_path import dp_pkg::*; ();

    localparam int TOTAL_BEATS = 12 + 16 + 10 + 40 + 5 + 12;
    localparam int CYCLE_LIMIT = TOTAL_BEATS * 8 + 200;

    logic                   clk = 1'b0;
    logic                   rst;
    axis_beat_t             i_in_beat;
    logic                   i_in_valid;
    logic                   o_in_ready;
    axis_beat_t             o_out_beat;
    logic                   o_out_valid;
    logic                   i_out_ready;
    logic                   i_done_loader;
    col_cfg_t [NUM_COL-1:0] cfg;
    logic                   o_done_steady;
    logic                   o_ap_done;

    logic [31:0] rnd_state = 32'd43;
    logic [31:0] rdy_state = 32'd43;   // separate stream for the sink
    logic        bp_mode;
    lane_t       model_acc [NUM_COL][NUM_LANES];
    lane_beat_t  exp_q [$];
    string       test_name = "reset";
    int          n_tests = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          errs_at_start = 0;
    int          cycles = 0;

    data_path i_dut (
        .clk           (clk),
        .rst           (rst),
        .i_in_beat     (i_in_beat),
        .i_in_valid    (i_in_valid),
        .o_in_ready    (o_in_ready),
        .o_out_beat    (o_out_beat),
        .o_out_valid   (o_out_valid),
        .i_out_ready   (i_out_ready),
        .i_done_loader (i_done_loader),
        .i_col_cfg     (cfg),
        .o_done_steady (o_done_steady),
        .o_ap_done     (o_ap_done)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_random();
        rnd_state = lcg_step(rnd_state);
        return rnd_state;
    endfunction

    function automatic keep_t keep_of(input lane_mask_t m);
        keep_t k;
        for (int l = 0; l < NUM_LANES; l++) begin
            k[l*LANE_KEEP +: LANE_KEEP] = {LANE_KEEP{m[l]}};
        end
        return k;
    endfunction

    // expected chain output with the model accumulators advanced per beat
    function automatic lane_beat_t chain_model(input axis_beat_t b);
        lane_beat_t r;
        lane_t      e;
        r.data = b.data;
        r.last = b.last;
        for (int l = 0; l < NUM_LANES; l++) begin
            r.lane_valid[l] = (b.keep[l*LANE_KEEP +: LANE_KEEP] == {LANE_KEEP{1'b1}});
        end
        for (int c = 0; c < NUM_COL; c++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (r.lane_valid[l]) begin
                    e = r.data[l*LANE_W +: LANE_W];
                    case (cfg[c].op)
                        OP_ADD: e = e + cfg[c].operand;
                        OP_MUL: e = e * cfg[c].operand;
                        OP_MAC: begin
                            model_acc[c][l] = model_acc[c][l] + e * cfg[c].operand;
                            e = model_acc[c][l];
                        end
                        default: e = e;
                    endcase
                    r.data[l*LANE_W +: LANE_W] = e;
                end
                if (b.last) begin
                    model_acc[c][l] = '0;   // sums restart with the next frame
                end
            end
        end
        return r;
    endfunction

    task automatic check_phit(input string what, input phit_t exp, input phit_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_keep(input string what, input keep_t exp, input keep_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_mask(input string what, input lane_mask_t exp, input lane_mask_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("** Error %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("** Error %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // sink ready is random only while back-pressure is on
    always @(posedge clk) begin : drive_ready
        rdy_state = lcg_step(rdy_state);
        i_out_ready <= bp_mode ? rdy_state[24] : 1'b1;
    end

    always @(posedge clk) begin : compare
        lane_beat_t exp_b;
        lane_mask_t act_mask;
        logic       exp_ap_done;
        logic       exp_steady;
        if (rst) begin
            for (int c = 0; c < NUM_COL; c++) begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    model_acc[c][l] = '0;
                end
            end
            exp_q.delete();
            exp_steady = 1'b0;
        end else begin
            exp_ap_done = 1'b0;
            check_flag("o_done_steady", exp_steady, o_done_steady);
            if (exp_steady) begin
                if (i_in_valid && o_in_ready) begin
                    exp_q.push_back(chain_model(i_in_beat));
                end
                if (o_out_valid && i_out_ready) begin
                    if (exp_q.size() == 0) begin
                        n_errors++;
                        $display("%s: an output beat came out with none expected", test_name);
                    end else begin
                        exp_b = exp_q.pop_front();
                        for (int l = 0; l < NUM_LANES; l++) begin
                            act_mask[l] = o_out_beat.keep[l*LANE_KEEP];
                        end
                        check_phit("data", exp_b.data, o_out_beat.data);
                        check_keep("keep", keep_of(exp_b.lane_valid), o_out_beat.keep);
                        check_mask("lanes", exp_b.lane_valid, act_mask);
                        check_flag("last", exp_b.last, o_out_beat.last);
                        if (exp_b.last) begin
                            exp_ap_done = 1'b1;
                            exp_steady  = 1'b0;   // off from the next cycle
                        end
                    end
                end
            end else begin
                // bypass has zero latency
                check_flag("bypass o_in_ready", i_out_ready, o_in_ready);
                check_flag("bypass o_out_valid", i_in_valid, o_out_valid);
                if (i_in_valid) begin
                    check_phit("bypass data", i_in_beat.data, o_out_beat.data);
                    check_keep("bypass keep", i_in_beat.keep, o_out_beat.keep);
                    check_flag("bypass last", i_in_beat.last, o_out_beat.last);
                end
                exp_steady = i_done_loader;
            end
            check_flag("o_ap_done", exp_ap_done, o_ap_done);
        end
    end

    always @(posedge clk) begin : watchdog
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: test %s still running after %0d cycles", test_name, cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic axis_beat_t make_beat(input logic last, input logic partial);
        axis_beat_t  b;
        logic [31:0] r;
        for (int l = 0; l < NUM_LANES; l++) begin
            b.data[l*LANE_W +: LANE_W] = next_random();
            r = next_random();
            if (partial && r[30:29] == 2'd0) begin
                b.keep[l*LANE_KEEP +: LANE_KEEP] = r[19:16];
            end else begin
                b.keep[l*LANE_KEEP +: LANE_KEEP] = {LANE_KEEP{1'b1}};
            end
        end
        b.last = last;
        return b;
    endfunction

    // returns on the edge that took the beat
    task automatic send_beat(input axis_beat_t b);
        i_in_beat  <= b;
        i_in_valid <= 1'b1;
        @(posedge clk);
        while (!o_in_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic run_frame(input col_op_e op0, input lane_t opd0, input col_op_e op1,
                             input lane_t opd1, input int n, input logic partial);
        cfg[0].op      <= op0;
        cfg[0].operand <= opd0;
        cfg[1].op      <= op1;
        cfg[1].operand <= opd1;
        i_done_loader  <= 1'b1;
        @(posedge clk);
        i_done_loader <= 1'b0;
        for (int i = 0; i < n; i++) begin
            send_beat(make_beat(i == n - 1, partial));
        end
        i_in_valid <= 1'b0;
        @(posedge clk);
        while (!o_ap_done) begin
            @(posedge clk);
        end
        @(posedge clk);
        check_flag("o_done_steady after frame end", 1'b0, o_done_steady);
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = n_errors;
        @(posedge clk);
    endtask

    task automatic finish_test();
        @(negedge clk);   // compare is done with the last edge
        if (exp_q.size() != 0) begin
            n_errors++;
            $display("%s: %0d expected beats never came out", test_name, exp_q.size());
        end
        n_tests++;
        if (n_errors == errs_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, n_errors - errs_at_start);
        end
    endtask

    initial begin
        logic [31:0] r;
        rst           <= 1'b1;
        i_in_beat     <= '0;
        i_in_valid    <= 1'b0;
        i_out_ready   <= 1'b1;
        i_done_loader <= 1'b0;
        cfg           <= '0;
        bp_mode       <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        start_test("bypass");
        bp_mode <= 1'b1;
        repeat (12) begin
            @(posedge clk);
            r = next_random();
            i_in_valid <= r[20];
            i_in_beat  <= make_beat(r[27], 1'b1);
        end
        @(posedge clk);
        i_in_valid <= 1'b0;
        bp_mode    <= 1'b0;
        @(posedge clk);
        finish_test();

        start_test("column_ops");
        run_frame(OP_PASS, 32'd0, OP_ADD, 32'd100, 8, 1'b0);
        run_frame(OP_MUL, 32'd3, OP_MAC, 32'd5, 8, 1'b0);
        finish_test();

        start_test("lane_gating");
        run_frame(OP_MAC, 32'd2, OP_MAC, 32'd3, 10, 1'b1);
        finish_test();

        start_test("back_pressure");
        bp_mode <= 1'b1;
        run_frame(OP_ADD, 32'd5, OP_MUL, 32'd7, 40, 1'b0);
        bp_mode <= 1'b0;
        finish_test();

        start_test("frame_end");
        run_frame(OP_ADD, 32'd1, OP_PASS, 32'd0, 4, 1'b0);
        send_beat(make_beat(1'b1, 1'b0));   // must go through the bypass
        i_in_valid <= 1'b0;
        @(posedge clk);
        finish_test();

        start_test("acc_clear");
        run_frame(OP_MAC, 32'd4, OP_MAC, 32'd9, 6, 1'b0);
        run_frame(OP_MAC, 32'd4, OP_MAC, 32'd9, 6, 1'b0);
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/dp_pkg.sv
verilog/sync_fifo.sv
verilog/steady_ctrl.sv
verilog/stream_in_stage.sv
verilog/column_pe.sv
verilog/stream_out_stage.sv
verilog/data_path.sv
testbench/tb_data_path.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f build.f --top-module tb_data_path
	out="$$(./obj_dir/Vtb_data_path)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
